//--- hw/rv_decode_pkg.sv
// RV64I base ISA only; alu_op codes are local to this stage and the U immediate is left unshifted
package rv_decode_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // one-hot, bit positions follow the execute stage's class decode
  typedef enum logic [7:0] {
    CLS_NONE = 8'h00,
    STORE    = 8'h01,
    LOAD     = 8'h02,
    BRANCH   = 8'h04,
    REGREG   = 8'h08,
    REGIMM   = 8'h10,
    REGIMMW  = 8'h20,
    REGREGW  = 8'h40,
    SYS      = 8'h80
  } inst_class_e;

  typedef enum logic [7:0] {
    OP_NONE = 8'd0,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LOAD, OP_STORE,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ECALL, OP_MRET,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_REG  = 2'd0,
    SRC_PC   = 2'd1,
    SRC_IMM  = 2'd2,
    SRC_ZERO = 2'd3
  } op_src_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    inst_class_e           inst_class;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic                  rs1_re;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs2_re;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       imm;
    op_src_e               op1_src;
    op_src_e               op2_src;
    logic [2:0]            mem_op;
    logic [11:0]           store_offset;
    logic                  is_jalr;
  } dec_t;

  // is_load only meaningful on the execute port
  typedef struct packed {
    logic                  ena;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
    logic                  is_load;
  } fwd_t;

  typedef struct packed {
    logic                  ena;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    inst_class_e           inst_class;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            mem_op;
    logic [11:0]           store_offset;
  } issue_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

//--- hw/pipe_reg.sv
// payload T must carry its valid flag, since flush zeroes the whole payload; flush wins over stall
module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic stall_i,
  input  logic flush_i,
  input  T     d_i,
  output T     q_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_o <= '0;
    end else if (flush_i) begin
      // bubble
      q_o <= '0;
    end else if (!stall_i) begin
      q_o <= d_i;
    end
  end

endmodule

//--- hw/regfile.sv
// x0 is hardwired to zero; a write and a read of the same register in one cycle return the new data
module regfile (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [rv_decode_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_decode_pkg::XLEN-1:0]       rdata2_o,
  input  rv_decode_pkg::wb_t                   wb_i
);

  logic [rv_decode_pkg::XLEN-1:0] regs [1:rv_decode_pkg::NUM_REGS-1];

  function automatic logic [rv_decode_pkg::XLEN-1:0] read_port(
    input logic [rv_decode_pkg::REG_ADDR_W-1:0] addr
  );
    if (addr == '0) return '0;
    // write-through bypass
    if (wb_i.ena && (wb_i.addr == addr)) return wb_i.data;
    return regs[addr];
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < rv_decode_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.ena && (wb_i.addr != '0)) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

//--- hw/inst_decoder.sv
// 32-bit encodings only (opcode[1:0] must be 11); unknown opcodes give class CLS_NONE and OP_NONE
module inst_decoder (
  input  rv_decode_pkg::fetch_t fetch_i,
  output rv_decode_pkg::dec_t   dec_o
);

  logic [31:0]                              inst;
  logic [6:0]                               opcode;
  logic [2:0]                               funct3;
  logic [6:0]                               funct7;
  logic [rv_decode_pkg::REG_ADDR_W-1:0]     rd;
  logic [rv_decode_pkg::REG_ADDR_W-1:0]     rs1;
  logic [rv_decode_pkg::REG_ADDR_W-1:0]     rs2;
  logic [11:0]                              s_imm12;
  logic [rv_decode_pkg::XLEN-1:0]           i_imm;
  logic [rv_decode_pkg::XLEN-1:0]           s_imm;
  logic [rv_decode_pkg::XLEN-1:0]           b_imm;
  logic [rv_decode_pkg::XLEN-1:0]           u_imm;
  logic [rv_decode_pkg::XLEN-1:0]           j_imm;
  rv_decode_pkg::inst_class_e               cls;
  rv_decode_pkg::alu_op_e                   op;
  logic                                     is_lui;
  logic                                     is_auipc;
  logic                                     is_jal;
  logic                                     is_jalr;
  logic                                     csr_reg;
  logic                                     csr_imm;
  logic                                     rs1_re;
  logic                                     rs2_re;

  assign inst    = fetch_i.inst;
  assign opcode  = inst[6:0];
  assign rd      = inst[11:7];
  assign funct3  = inst[14:12];
  assign rs1     = inst[19:15];
  assign rs2     = inst[24:20];
  assign funct7  = inst[31:25];
  assign s_imm12 = {inst[31:25], inst[11:7]};

  assign i_imm = {{52{inst[31]}}, inst[31:20]};
  assign s_imm = {{52{inst[31]}}, s_imm12};
  assign b_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  // raw 20-bit field, execute applies the shift by 12
  assign u_imm = {{44{inst[31]}}, inst[31:12]};
  assign j_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_lui   = (opcode == 7'b0110111);
  assign is_auipc = (opcode == 7'b0010111);
  assign is_jal   = (opcode == 7'b1101111);
  assign is_jalr  = (opcode == 7'b1100111);

  always_comb begin : classify
    case (opcode)
      7'b1110011: cls = rv_decode_pkg::SYS;
      7'b0111011: cls = rv_decode_pkg::REGREGW;
      7'b0011011: cls = rv_decode_pkg::REGIMMW;
      7'b0010011: cls = rv_decode_pkg::REGIMM;
      7'b0110011: cls = rv_decode_pkg::REGREG;
      7'b1100011: cls = rv_decode_pkg::BRANCH;
      7'b0000011: cls = rv_decode_pkg::LOAD;
      7'b0100011: cls = rv_decode_pkg::STORE;
      default:    cls = rv_decode_pkg::CLS_NONE;
    endcase
  end

  assign csr_reg = (cls == rv_decode_pkg::SYS) && (funct3 inside {3'b001, 3'b010, 3'b011});
  assign csr_imm = (cls == rv_decode_pkg::SYS) && (funct3 inside {3'b101, 3'b110, 3'b111});

  always_comb begin : op_select
    op = rv_decode_pkg::OP_NONE;
    case (cls)
      rv_decode_pkg::REGIMM: begin
        case (funct3)
          3'b000:  op = rv_decode_pkg::OP_ADDI;
          3'b001:  op = rv_decode_pkg::OP_SLLI;
          3'b010:  op = rv_decode_pkg::OP_SLTI;
          3'b011:  op = rv_decode_pkg::OP_SLTIU;
          3'b100:  op = rv_decode_pkg::OP_XORI;
          3'b101:  op = inst[30] ? rv_decode_pkg::OP_SRAI : rv_decode_pkg::OP_SRLI;
          3'b110:  op = rv_decode_pkg::OP_ORI;
          default: op = rv_decode_pkg::OP_ANDI;
        endcase
      end
      rv_decode_pkg::REGIMMW: begin
        case (funct3)
          3'b000:  op = rv_decode_pkg::OP_ADDIW;
          3'b001:  op = rv_decode_pkg::OP_SLLIW;
          3'b101:  op = inst[30] ? rv_decode_pkg::OP_SRAIW : rv_decode_pkg::OP_SRLIW;
          default: op = rv_decode_pkg::OP_NONE;
        endcase
      end
      rv_decode_pkg::REGREG: begin
        case (funct3)
          3'b000:  op = funct7[5] ? rv_decode_pkg::OP_SUB : rv_decode_pkg::OP_ADD;
          3'b001:  op = rv_decode_pkg::OP_SLL;
          3'b010:  op = rv_decode_pkg::OP_SLT;
          3'b011:  op = rv_decode_pkg::OP_SLTU;
          3'b100:  op = rv_decode_pkg::OP_XOR;
          3'b101:  op = funct7[5] ? rv_decode_pkg::OP_SRA : rv_decode_pkg::OP_SRL;
          3'b110:  op = rv_decode_pkg::OP_OR;
          default: op = rv_decode_pkg::OP_AND;
        endcase
      end
      rv_decode_pkg::REGREGW: begin
        case (funct3)
          3'b000:  op = funct7[5] ? rv_decode_pkg::OP_SUBW : rv_decode_pkg::OP_ADDW;
          3'b001:  op = rv_decode_pkg::OP_SLLW;
          3'b101:  op = funct7[5] ? rv_decode_pkg::OP_SRAW : rv_decode_pkg::OP_SRLW;
          default: op = rv_decode_pkg::OP_NONE;
        endcase
      end
      rv_decode_pkg::BRANCH: begin
        case (funct3)
          3'b000:  op = rv_decode_pkg::OP_BEQ;
          3'b001:  op = rv_decode_pkg::OP_BNE;
          3'b100:  op = rv_decode_pkg::OP_BLT;
          3'b101:  op = rv_decode_pkg::OP_BGE;
          3'b110:  op = rv_decode_pkg::OP_BLTU;
          3'b111:  op = rv_decode_pkg::OP_BGEU;
          default: op = rv_decode_pkg::OP_NONE;
        endcase
      end
      rv_decode_pkg::SYS: begin
        case (funct3)
          3'b000:  op = (funct7 == 7'b0011000) ? rv_decode_pkg::OP_MRET : rv_decode_pkg::OP_ECALL;
          3'b001:  op = rv_decode_pkg::OP_CSRRW;
          3'b010:  op = rv_decode_pkg::OP_CSRRS;
          3'b011:  op = rv_decode_pkg::OP_CSRRC;
          3'b101:  op = rv_decode_pkg::OP_CSRRWI;
          3'b110:  op = rv_decode_pkg::OP_CSRRSI;
          3'b111:  op = rv_decode_pkg::OP_CSRRCI;
          default: op = rv_decode_pkg::OP_NONE;
        endcase
      end
      rv_decode_pkg::LOAD:  op = rv_decode_pkg::OP_LOAD;
      rv_decode_pkg::STORE: op = rv_decode_pkg::OP_STORE;
      default: begin
        if (is_lui) op = rv_decode_pkg::OP_LUI;
        else if (is_auipc) op = rv_decode_pkg::OP_AUIPC;
        else if (is_jal) op = rv_decode_pkg::OP_JAL;
        else if (is_jalr) op = rv_decode_pkg::OP_JALR;
      end
    endcase
  end

  // jalr reads rs1 for its target
  assign rs1_re = (cls inside {rv_decode_pkg::REGREGW, rv_decode_pkg::REGIMMW,
                               rv_decode_pkg::REGIMM, rv_decode_pkg::REGREG,
                               rv_decode_pkg::BRANCH, rv_decode_pkg::LOAD,
                               rv_decode_pkg::STORE}) || csr_reg || is_jalr;
  assign rs2_re = cls inside {rv_decode_pkg::REGREGW, rv_decode_pkg::REGREG,
                              rv_decode_pkg::BRANCH, rv_decode_pkg::STORE};

  always_comb begin : assemble
    dec_o = '0;
    if (fetch_i.valid) begin
      dec_o.inst_class = cls;
      dec_o.alu_op     = op;
      dec_o.rs1        = rs1;
      dec_o.rs1_re     = rs1_re;
      dec_o.rs2        = rs2;
      dec_o.rs2_re     = rs2_re;
      dec_o.rd_we      = (rd != '0) && ((cls inside {rv_decode_pkg::SYS, rv_decode_pkg::REGREGW,
                                                     rv_decode_pkg::REGIMMW, rv_decode_pkg::REGIMM,
                                                     rv_decode_pkg::REGREG, rv_decode_pkg::LOAD})
                                        || is_lui || is_auipc || is_jal || is_jalr);
      dec_o.rd         = dec_o.rd_we ? rd : '0;
      if (cls == rv_decode_pkg::STORE) dec_o.imm = s_imm;
      else if (cls == rv_decode_pkg::BRANCH) dec_o.imm = b_imm;
      else if (is_lui || is_auipc) dec_o.imm = u_imm;
      else if (is_jal) dec_o.imm = j_imm;
      else dec_o.imm = i_imm;
      if (rs1_re) dec_o.op1_src = rv_decode_pkg::SRC_REG;
      else if (is_auipc || is_jal) dec_o.op1_src = rv_decode_pkg::SRC_PC;
      else if (csr_imm) dec_o.op1_src = rv_decode_pkg::SRC_IMM;
      else dec_o.op1_src = rv_decode_pkg::SRC_ZERO;
      if (rs2_re) dec_o.op2_src = rv_decode_pkg::SRC_REG;
      else if ((cls inside {rv_decode_pkg::REGIMM, rv_decode_pkg::REGIMMW, rv_decode_pkg::SYS})
               || is_lui || is_auipc) dec_o.op2_src = rv_decode_pkg::SRC_IMM;
      else if (is_jal || is_jalr) dec_o.op2_src = rv_decode_pkg::SRC_PC;
      else dec_o.op2_src = rv_decode_pkg::SRC_ZERO;
      dec_o.mem_op     = funct3;
      if (cls == rv_decode_pkg::LOAD) dec_o.store_offset = inst[31:20];
      else if (cls == rv_decode_pkg::STORE) dec_o.store_offset = s_imm12;
      dec_o.is_jalr    = is_jalr;
    end
  end

endmodule

//--- hw/operand_forward.sv
// execute beats memory beats register file; no JALR prediction, every JALR redirects when not stalled
module operand_forward (
  input  rv_decode_pkg::dec_t             dec_i,
  input  logic [rv_decode_pkg::XLEN-1:0]  pc_i,
  input  logic                            valid_i,
  input  logic [rv_decode_pkg::XLEN-1:0]  rdata1_i,
  input  logic [rv_decode_pkg::XLEN-1:0]  rdata2_i,
  input  rv_decode_pkg::fwd_t             ex_fwd_i,
  input  rv_decode_pkg::fwd_t             mem_fwd_i,
  output logic [rv_decode_pkg::XLEN-1:0]  op1_o,
  output logic [rv_decode_pkg::XLEN-1:0]  op2_o,
  output logic                            stall_o,
  output rv_decode_pkg::redirect_t        redirect_o
);

  logic                           ex_hit1;
  logic                           ex_hit2;
  logic                           mem_hit1;
  logic                           mem_hit2;
  logic [rv_decode_pkg::XLEN-1:0] reg1;
  logic [rv_decode_pkg::XLEN-1:0] reg2;
  logic [rv_decode_pkg::XLEN-1:0] target;

  // x0 never matches, its value is always zero
  function automatic logic src_hit(input logic re,
                                   input logic [rv_decode_pkg::REG_ADDR_W-1:0] addr,
                                   input rv_decode_pkg::fwd_t src);
    return re && (addr != '0) && src.ena && (src.addr == addr);
  endfunction

  assign ex_hit1  = src_hit(dec_i.rs1_re, dec_i.rs1, ex_fwd_i);
  assign ex_hit2  = src_hit(dec_i.rs2_re, dec_i.rs2, ex_fwd_i);
  assign mem_hit1 = src_hit(dec_i.rs1_re, dec_i.rs1, mem_fwd_i);
  assign mem_hit2 = src_hit(dec_i.rs2_re, dec_i.rs2, mem_fwd_i);

  assign reg1 = ex_hit1 ? ex_fwd_i.data : (mem_hit1 ? mem_fwd_i.data : rdata1_i);
  assign reg2 = ex_hit2 ? ex_fwd_i.data : (mem_hit2 ? mem_fwd_i.data : rdata2_i);

  // load result not available until after memory
  assign stall_o = ex_fwd_i.is_load && (ex_hit1 || ex_hit2);

  always_comb begin : op1_mux
    case (dec_i.op1_src)
      rv_decode_pkg::SRC_REG: op1_o = reg1;
      rv_decode_pkg::SRC_PC:  op1_o = pc_i;
      rv_decode_pkg::SRC_IMM: op1_o = {{(rv_decode_pkg::XLEN-5){1'b0}}, dec_i.rs1};
      default:                op1_o = '0;
    endcase
  end

  always_comb begin : op2_mux
    case (dec_i.op2_src)
      rv_decode_pkg::SRC_REG: op2_o = reg2;
      rv_decode_pkg::SRC_PC:  op2_o = pc_i;
      rv_decode_pkg::SRC_IMM: op2_o = dec_i.imm;
      default:                op2_o = '0;
    endcase
  end

  assign target           = dec_i.imm + reg1;
  assign redirect_o.valid = valid_i && dec_i.is_jalr && !stall_o;
  assign redirect_o.pc    = {target[rv_decode_pkg::XLEN-1:1], 1'b0};

endmodule

//--- hw/decode_stage.sv
// execute is assumed to always accept; a stall bubbles ID/EX and a redirect drops the IF/ID slot
module decode_stage (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  rv_decode_pkg::fetch_t     fetch_i,
  input  rv_decode_pkg::fwd_t       ex_fwd_i,
  input  rv_decode_pkg::fwd_t       mem_fwd_i,
  input  rv_decode_pkg::wb_t        wb_i,
  output logic                      stall_o,
  output rv_decode_pkg::redirect_t  redirect_o,
  output rv_decode_pkg::issue_t     issue_o
);

  rv_decode_pkg::fetch_t                if_id_q;
  rv_decode_pkg::dec_t                  dec;
  rv_decode_pkg::issue_t                issue_d;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] raddr1;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] raddr2;
  logic [rv_decode_pkg::XLEN-1:0]       rdata1;
  logic [rv_decode_pkg::XLEN-1:0]       rdata2;
  logic [rv_decode_pkg::XLEN-1:0]       op1;
  logic [rv_decode_pkg::XLEN-1:0]       op2;

  pipe_reg #(.T(rv_decode_pkg::fetch_t)) if_id_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_o),
    .flush_i  (redirect_o.valid),
    .d_i      (fetch_i),
    .q_o      (if_id_q)
  );

  inst_decoder inst_decoder_i (
    .fetch_i (if_id_q),
    .dec_o   (dec)
  );

  // unused ports read x0
  assign raddr1 = dec.rs1_re ? dec.rs1 : '0;
  assign raddr2 = dec.rs2_re ? dec.rs2 : '0;

  regfile regfile_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb_i)
  );

  operand_forward operand_forward_i (
    .dec_i      (dec),
    .pc_i       (if_id_q.pc),
    .valid_i    (if_id_q.valid),
    .rdata1_i   (rdata1),
    .rdata2_i   (rdata2),
    .ex_fwd_i   (ex_fwd_i),
    .mem_fwd_i  (mem_fwd_i),
    .op1_o      (op1),
    .op2_o      (op2),
    .stall_o    (stall_o),
    .redirect_o (redirect_o)
  );

  assign issue_d = '{
    valid:        if_id_q.valid,
    pc:           if_id_q.pc,
    inst_class:   dec.inst_class,
    alu_op:       dec.alu_op,
    op1:          op1,
    op2:          op2,
    rd_we:        dec.rd_we,
    rd:           dec.rd,
    mem_op:       dec.mem_op,
    store_offset: dec.store_offset
  };

  pipe_reg #(.T(rv_decode_pkg::issue_t)) id_ex_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (1'b0),
    .flush_i  (stall_o),
    .d_i      (issue_d),
    .q_o      (issue_o)
  );

endmodule

//--- testbench/decode_stage_assertions.sv
// pipeline control invariants only; operand values are not covered here
module decode_stage_assertions (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     stall_i,
  input rv_decode_pkg::redirect_t redirect_i,
  input rv_decode_pkg::issue_t    issue_i
);

  // number of failed checks
  int fail_cnt = 0;

  // every stalled cycle loads a bubble into ID/EX
  bubble_after_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) stall_i |=> !issue_i.valid
  ) else begin
    $error("issue valid in the cycle after a stall");
    fail_cnt++;
  end

  no_redirect_while_stalled: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(stall_i && redirect_i.valid)
  ) else begin
    $error("redirect and stall active together");
    fail_cnt++;
  end

  no_write_to_x0: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (issue_i.rd == '0) |-> !issue_i.rd_we
  ) else begin
    $error("issue with rd x0 has rd_we set");
    fail_cnt++;
  end

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_i (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .stall_i    (stall_o),
  .redirect_i (redirect_o),
  .issue_i    (issue_o)
);

//--- testbench/tb_decode_stage.sv
// register values come from an LFSR preload; LUI/AUIPC op2 is expected as the unshifted U field
module tb_decode_stage;

  localparam int RESET_CYCLES    = 8;
  localparam int PRELOAD_CYCLES  = 33;
  localparam int ALU_CYCLES      = 18;
  localparam int FWD_CYCLES      = 12;
  localparam int STALL_CYCLES    = 9;
  localparam int JALR_CYCLES     = 6;
  localparam int LDST_CYCLES     = 6;
  localparam int MARGIN_CYCLES   = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + PRELOAD_CYCLES + ALU_CYCLES + FWD_CYCLES
                                   + STALL_CYCLES + JALR_CYCLES + LDST_CYCLES + MARGIN_CYCLES;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP32   = 7'b0111011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  logic                     clk_i;
  logic                     arst_n_i;
  rv_decode_pkg::fetch_t    fetch_i;
  rv_decode_pkg::fwd_t      ex_fwd_i;
  rv_decode_pkg::fwd_t      mem_fwd_i;
  rv_decode_pkg::wb_t       wb_i;
  logic                     stall_o;
  rv_decode_pkg::redirect_t redirect_o;
  rv_decode_pkg::issue_t    issue_o;

  logic [63:0] reg_model [0:31];
  logic [15:0] lfsr_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  decode_stage decode_stage_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .fetch_i    (fetch_i),
    .ex_fwd_i   (ex_fwd_i),
    .mem_fwd_i  (mem_fwd_i),
    .wb_i       (wb_i),
    .stall_o    (stall_o),
    .redirect_o (redirect_o),
    .issue_o    (issue_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // 16-bit Galois LFSR with taps at 16 14 13 11
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < 64; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] sext20(input logic [19:0] v);
    return {{44{v[19]}}, v};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_val("issue_o.valid", 64'd0, issue_o.valid);
    check_val("stall_o", 64'd0, stall_o);
    check_val("redirect_o.valid", 64'd0, redirect_o.valid);
  endtask

  task automatic check_issue(input logic [63:0] pc, input logic [7:0] cls,
                             input logic [7:0] op, input logic [63:0] op1,
                             input logic [63:0] op2, input logic rd_we,
                             input logic [4:0] rd, input logic [11:0] offset);
    check_val("issue_o.valid", 64'd1, issue_o.valid);
    check_val("issue_o.pc", pc, issue_o.pc);
    check_val("issue_o.inst_class", cls, issue_o.inst_class);
    check_val("issue_o.alu_op", op, issue_o.alu_op);
    check_val("issue_o.op1", op1, issue_o.op1);
    check_val("issue_o.op2", op2, issue_o.op2);
    check_val("issue_o.rd_we", rd_we, issue_o.rd_we);
    if (rd_we) check_val("issue_o.rd", rd, issue_o.rd);
    check_val("issue_o.store_offset", offset, issue_o.store_offset);
  endtask

  // feedback ports are live only while the instruction sits in IF/ID
  task automatic issue_with(input logic [63:0] pc, input logic [31:0] inst,
                            input rv_decode_pkg::fwd_t ex, input rv_decode_pkg::fwd_t mem,
                            input rv_decode_pkg::wb_t wb);
    next_cycle();
    fetch_i = '{valid: 1'b1, pc: pc, inst: inst};
    next_cycle();
    fetch_i   = '0;
    ex_fwd_i  = ex;
    mem_fwd_i = mem;
    wb_i      = wb;
    next_cycle();
    ex_fwd_i  = '0;
    mem_fwd_i = '0;
    wb_i      = '0;
  endtask

  task automatic finish_test(input string name, input int start);
    if (errors == start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - start);
    end
  endtask

  task automatic preload_regs();
    logic [63:0] value;
    reg_model[0] = '0;
    for (int r = 1; r < 32; r++) begin
      next_cycle();
      value = rand64();
      wb_i = '{ena: 1'b1, addr: 5'(r), data: value};
      reg_model[r] = value;
    end
    next_cycle();
    wb_i = '0;
  endtask

  task automatic reset_idle();
    int start;
    start = errors;
    repeat (RESET_CYCLES) begin
      next_cycle();
      check_idle();
    end
    arst_n_i = 1'b1;
    next_cycle();
    check_idle();
    finish_test("reset", start);
  endtask

  task automatic alu_decode();
    int          start;
    logic [63:0] pc;
    start = errors;
    pc = 64'h0000_0000_8000_0100;
    issue_with(pc, i_type(12'hFDB, 5'd3, 3'b000, 5'd5, OPC_OPIMM), '0, '0, '0);
    check_issue(pc, rv_decode_pkg::REGIMM, rv_decode_pkg::OP_ADDI, reg_model[3],
                sext12(12'hFDB), 1'b1, 5'd5, 12'h0);
    issue_with(pc + 4, r_type(7'b0100000, 5'd9, 5'd4, 3'b000, 5'd7, OPC_OP), '0, '0, '0);
    check_issue(pc + 4, rv_decode_pkg::REGREG, rv_decode_pkg::OP_SUB, reg_model[4],
                reg_model[9], 1'b1, 5'd7, 12'h0);
    // rd = x0 must not write
    issue_with(pc + 8, r_type(7'b0, 5'd11, 5'd12, 3'b000, 5'd0, OPC_OP32), '0, '0, '0);
    check_issue(pc + 8, rv_decode_pkg::REGREGW, rv_decode_pkg::OP_ADDW, reg_model[12],
                reg_model[11], 1'b0, 5'd0, 12'h0);
    issue_with(pc + 12, i_type(12'h405, 5'd13, 3'b101, 5'd8, OPC_OPIMM), '0, '0, '0);
    check_issue(pc + 12, rv_decode_pkg::REGIMM, rv_decode_pkg::OP_SRAI, reg_model[13],
                sext12(12'h405), 1'b1, 5'd8, 12'h0);
    issue_with(pc + 16, u_type(20'hABCDE, 5'd10, OPC_LUI), '0, '0, '0);
    check_issue(pc + 16, rv_decode_pkg::CLS_NONE, rv_decode_pkg::OP_LUI, 64'd0,
                sext20(20'hABCDE), 1'b1, 5'd10, 12'h0);
    issue_with(pc + 20, u_type(20'h12345, 5'd14, OPC_AUIPC), '0, '0, '0);
    check_issue(pc + 20, rv_decode_pkg::CLS_NONE, rv_decode_pkg::OP_AUIPC, pc + 20,
                sext20(20'h12345), 1'b1, 5'd14, 12'h0);
    finish_test("alu decode", start);
  endtask

  task automatic forwarding_priority();
    int                  start;
    logic [63:0]         pc;
    logic [31:0]         inst;
    rv_decode_pkg::fwd_t ex;
    rv_decode_pkg::fwd_t mem;
    rv_decode_pkg::wb_t  wb;
    start = errors;
    pc    = 64'h0000_0000_8000_0200;
    inst  = r_type(7'b0, 5'd6, 5'd6, 3'b000, 5'd15, OPC_OP);
    ex    = '{ena: 1'b1, addr: 5'd6, data: rand64(), is_load: 1'b0};
    mem   = '{ena: 1'b1, addr: 5'd6, data: rand64(), is_load: 1'b0};
    issue_with(pc, inst, ex, mem, '0);
    check_issue(pc, rv_decode_pkg::REGREG, rv_decode_pkg::OP_ADD, ex.data, ex.data,
                1'b1, 5'd15, 12'h0);
    ex.ena = 1'b0;
    issue_with(pc, inst, ex, mem, '0);
    check_issue(pc, rv_decode_pkg::REGREG, rv_decode_pkg::OP_ADD, mem.data, mem.data,
                1'b1, 5'd15, 12'h0);
    mem.ena = 1'b0;
    issue_with(pc, inst, ex, mem, '0);
    check_issue(pc, rv_decode_pkg::REGREG, rv_decode_pkg::OP_ADD, reg_model[6], reg_model[6],
                1'b1, 5'd15, 12'h0);
    // write in the same cycle as the read
    wb = '{ena: 1'b1, addr: 5'd6, data: rand64()};
    issue_with(pc, inst, '0, '0, wb);
    reg_model[6] = wb.data;
    check_issue(pc, rv_decode_pkg::REGREG, rv_decode_pkg::OP_ADD, reg_model[6], reg_model[6],
                1'b1, 5'd15, 12'h0);
    finish_test("forwarding priority", start);
  endtask

  task automatic load_use_stall();
    int                  start;
    logic [63:0]         pc;
    rv_decode_pkg::fwd_t ex;
    start = errors;
    pc    = 64'h0000_0000_8000_0300;
    ex    = '{ena: 1'b1, addr: 5'd17, data: rand64(), is_load: 1'b1};
    next_cycle();
    fetch_i = '{valid: 1'b1, pc: pc, inst: r_type(7'b0, 5'd18, 5'd17, 3'b000, 5'd16, OPC_OP)};
    next_cycle();
    fetch_i  = '0;
    ex_fwd_i = ex;
    #1;
    check_val("stall_o", 64'd1, stall_o);
    repeat (2) begin
      next_cycle();
      check_val("issue_o.valid", 64'd0, issue_o.valid);
      check_val("stall_o", 64'd1, stall_o);
    end
    // load data now comes back as a plain forward
    ex_fwd_i.is_load = 1'b0;
    #1;
    check_val("stall_o", 64'd0, stall_o);
    next_cycle();
    ex_fwd_i = '0;
    check_issue(pc, rv_decode_pkg::REGREG, rv_decode_pkg::OP_ADD, ex.data, reg_model[18],
                1'b1, 5'd16, 12'h0);
    ex = '{ena: 1'b1, addr: 5'd0, data: rand64(), is_load: 1'b1};
    next_cycle();
    fetch_i = '{valid: 1'b1, pc: pc + 4, inst: i_type(12'd5, 5'd0, 3'b000, 5'd19, OPC_OPIMM)};
    next_cycle();
    fetch_i  = '0;
    ex_fwd_i = ex;
    #1;
    check_val("stall_o", 64'd0, stall_o);
    next_cycle();
    ex_fwd_i = '0;
    check_issue(pc + 4, rv_decode_pkg::REGIMM, rv_decode_pkg::OP_ADDI, 64'd0, 64'd5,
                1'b1, 5'd19, 12'h0);
    finish_test("load-use stall", start);
  endtask

  task automatic jalr_redirect();
    int                  start;
    logic [63:0]         pc;
    logic [63:0]         target;
    rv_decode_pkg::fwd_t ex;
    rv_decode_pkg::fwd_t mem;
    start  = errors;
    pc     = 64'h0000_0000_8000_0400;
    ex     = '{ena: 1'b1, addr: 5'd20, data: rand64(), is_load: 1'b1};
    mem    = '{ena: 1'b1, addr: 5'd20, data: rand64(), is_load: 1'b0};
    target = mem.data + sext12(12'h7F3);
    target[0] = 1'b0;
    next_cycle();
    fetch_i = '{valid: 1'b1, pc: pc, inst: i_type(12'h7F3, 5'd20, 3'b000, 5'd1, OPC_JALR)};
    next_cycle();
    // rs1 still in flight as a load
    fetch_i  = '0;
    ex_fwd_i = ex;
    #1;
    check_val("stall_o", 64'd1, stall_o);
    check_val("redirect_o.valid", 64'd0, redirect_o.valid);
    next_cycle();
    // wrong-path fetch arrives together with the redirect
    fetch_i   = '{valid: 1'b1, pc: pc + 4, inst: i_type(12'd1, 5'd0, 3'b000, 5'd21, OPC_OPIMM)};
    ex_fwd_i  = '0;
    mem_fwd_i = mem;
    #1;
    check_val("issue_o.valid", 64'd0, issue_o.valid);
    check_val("redirect_o.valid", 64'd1, redirect_o.valid);
    check_val("redirect_o.pc", target, redirect_o.pc);
    check_val("stall_o", 64'd0, stall_o);
    next_cycle();
    fetch_i   = '{valid: 1'b1, pc: target, inst: i_type(12'd2, 5'd0, 3'b000, 5'd22, OPC_OPIMM)};
    mem_fwd_i = '0;
    check_issue(pc, rv_decode_pkg::CLS_NONE, rv_decode_pkg::OP_JALR, mem.data, pc,
                1'b1, 5'd1, 12'h0);
    #1;
    check_val("redirect_o.valid", 64'd0, redirect_o.valid);
    next_cycle();
    fetch_i = '0;
    check_val("issue_o.valid", 64'd0, issue_o.valid);
    next_cycle();
    check_issue(target, rv_decode_pkg::REGIMM, rv_decode_pkg::OP_ADDI, 64'd0, 64'd2,
                1'b1, 5'd22, 12'h0);
    finish_test("jalr redirect", start);
  endtask

  task automatic load_store_fields();
    int          start;
    logic [63:0] pc;
    start = errors;
    pc    = 64'h0000_0000_8000_0500;
    issue_with(pc, s_type(12'hA55, 5'd23, 5'd24, 3'b011, OPC_STORE), '0, '0, '0);
    check_issue(pc, rv_decode_pkg::STORE, rv_decode_pkg::OP_STORE, reg_model[24],
                reg_model[23], 1'b0, 5'd0, 12'hA55);
    check_val("issue_o.mem_op", 64'd3, issue_o.mem_op);
    issue_with(pc + 4, i_type(12'h123, 5'd26, 3'b010, 5'd25, OPC_LOAD), '0, '0, '0);
    check_issue(pc + 4, rv_decode_pkg::LOAD, rv_decode_pkg::OP_LOAD, reg_model[26], 64'd0,
                1'b1, 5'd25, 12'h123);
    check_val("issue_o.mem_op", 64'd2, issue_o.mem_op);
    finish_test("load/store fields", start);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int assert_fails;
    arst_n_i     = 1'b0;
    fetch_i      = '0;
    ex_fwd_i     = '0;
    mem_fwd_i    = '0;
    wb_i         = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state   = 16'd53847;
    reset_idle();
    preload_regs();
    alu_decode();
    forwarding_priority();
    load_use_stall();
    jalr_redirect();
    load_store_fields();
    next_cycle();
    assert_fails = decode_stage_i.decode_stage_assertions_i.fail_cnt;
    if (assert_fails != 0) begin
      $display("concurrent assertions failed %0d times", assert_fails);
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if ((tests_failed == 0) && (assert_fails == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/rv_decode_pkg.sv
hw/pipe_reg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/decode_stage.sv
testbench/decode_stage_assertions.sv
testbench/tb_decode_stage.sv

//--- Bender.yml
package:
  name: rv64_decode_stage

sources:
  # RTL, package first
  - hw/rv_decode_pkg.sv
  - hw/pipe_reg.sv
  - hw/regfile.sv
  - hw/inst_decoder.sv
  - hw/operand_forward.sv
  - hw/decode_stage.sv

  # testbench, top module tb_decode_stage
  - target: test
    files:
      - testbench/decode_stage_assertions.sv
      - testbench/tb_decode_stage.sv
